/* Makefile */
VERILATOR ?= verilator
TOP       ?= gat_writeback_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+include
hw/gat_pkg.sv
hw/feat_fifo.sv
hw/subgraph_index_ram.sv
hw/h_data_ram.sv
hw/subgraph_handler.sv
hw/gat_writeback_top.sv
testbench/gat_writeback_props.sv
testbench/gat_writeback_tb.sv

/* hw/feat_fifo.sv */
module feat_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_push;
  logic               do_pop;

  // Overflow and underflow requests are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));

  // Head of the queue is always visible
  assign dout = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* hw/gat_pkg.sv */
`include "gat_settings.svh"

package gat_pkg;

  // One feature word and a whole output vector
  typedef logic [`GAT_FEAT_WIDTH-1:0] feat_t;
  typedef feat_t [`GAT_NUM_FEAT_OUT-1:0] feat_vec_t;

  // Row number inside H
  typedef logic [$clog2(`GAT_NUM_NODES)-1:0] node_idx_t;

  // Index list entry, same bit order as the stored word
  typedef struct packed {
    logic      sog;
    node_idx_t node_idx;
    logic      eog;
  } sg_entry_t;

  typedef logic [$clog2(`GAT_TOTAL_ENTRIES)-1:0] entry_addr_t;

  // Word address into H, row major
  typedef logic [$clog2(`GAT_NUM_NODES*`GAT_NUM_FEAT_OUT)-1:0] h_addr_t;

  typedef logic [$clog2(`GAT_NUM_FEAT_OUT)-1:0] word_idx_t;

endpackage

/* hw/gat_writeback_top.sv */
`include "gat_settings.svh"

module gat_writeback_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  gat_pkg::feat_vec_t     new_feat,
  input  logic                   new_feat_vld,
  output logic                   new_feat_rdy,
  input  logic                   idx_wr_en,
  input  gat_pkg::entry_addr_t   idx_wr_addr,
  input  gat_pkg::sg_entry_t     idx_wr_data,
  input  logic                   start,
  input  gat_pkg::h_addr_t       h_rd_addr,
  output gat_pkg::feat_t         h_rd_data,
  output logic                   gat_ready
);

  gat_pkg::feat_vec_t     fifo_dout;
  logic                   fifo_empty;
  logic                   fifo_full;
  logic                   fifo_push;
  logic                   fifo_pop;
  gat_pkg::entry_addr_t   idx_rd_addr;
  gat_pkg::sg_entry_t     idx_rd_data;
  logic                   h_wr_en;
  gat_pkg::h_addr_t       h_wr_addr;
  gat_pkg::feat_t         h_wr_data;

  // Ready follows FIFO space only
  assign new_feat_rdy = !fifo_full;
  assign fifo_push    = new_feat_vld && new_feat_rdy;

  feat_fifo #(
    .payload_t (gat_pkg::feat_vec_t),
    .DEPTH     (`GAT_FIFO_DEPTH)
  ) u_feat_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (fifo_push),
    .din   (new_feat),
    .pop   (fifo_pop),
    .dout  (fifo_dout),
    .empty (fifo_empty),
    .full  (fifo_full)
  );

  subgraph_index_ram u_index_ram (
    .clk     (clk),
    .wr_en   (idx_wr_en),
    .wr_addr (idx_wr_addr),
    .wr_data (idx_wr_data),
    .rd_addr (idx_rd_addr),
    .rd_data (idx_rd_data)
  );

  h_data_ram u_h_data_ram (
    .clk     (clk),
    .wr_en   (h_wr_en),
    .wr_addr (h_wr_addr),
    .wr_data (h_wr_data),
    .rd_addr (h_rd_addr),
    .rd_data (h_rd_data)
  );

  subgraph_handler u_handler (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .idx_rd_data (idx_rd_data),
    .fifo_dout   (fifo_dout),
    .fifo_empty  (fifo_empty),
    .idx_rd_addr (idx_rd_addr),
    .fifo_pop    (fifo_pop),
    .h_wr_en     (h_wr_en),
    .h_wr_addr   (h_wr_addr),
    .h_wr_data   (h_wr_data),
    .gat_ready   (gat_ready)
  );

endmodule

/* hw/h_data_ram.sv */
`include "gat_settings.svh"

module h_data_ram (
  input  logic               clk,
  input  logic               wr_en,
  input  gat_pkg::h_addr_t   wr_addr,
  input  gat_pkg::feat_t     wr_data,
  input  gat_pkg::h_addr_t   rd_addr,
  output gat_pkg::feat_t     rd_data
);

  localparam int H_DEPTH = `GAT_NUM_NODES * `GAT_NUM_FEAT_OUT;

  // One word per node and output feature
  gat_pkg::feat_t mem [H_DEPTH];

  // Scatter port from the handler
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Readback port, data one cycle after address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hw/subgraph_handler.sv */
`include "gat_settings.svh"

module subgraph_handler (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  gat_pkg::sg_entry_t     idx_rd_data,
  input  gat_pkg::feat_vec_t     fifo_dout,
  input  logic                   fifo_empty,
  output gat_pkg::entry_addr_t   idx_rd_addr,
  output logic                   fifo_pop,
  output logic                   h_wr_en,
  output gat_pkg::h_addr_t       h_wr_addr,
  output gat_pkg::feat_t         h_wr_data,
  output logic                   gat_ready
);

  localparam gat_pkg::entry_addr_t LAST_ENTRY =
    gat_pkg::entry_addr_t'(`GAT_TOTAL_ENTRIES - 1);
  localparam gat_pkg::word_idx_t LAST_WORD =
    gat_pkg::word_idx_t'(`GAT_NUM_FEAT_OUT - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_LATCH,
    S_LOAD,
    S_WRITE,
    S_DONE
  } state_t;

  state_t                 state_q;
  gat_pkg::entry_addr_t   entry_addr_q;
  gat_pkg::sg_entry_t     entry_q;
  gat_pkg::feat_vec_t     vec_q;
  gat_pkg::word_idx_t     word_cnt_q;
  logic                   last_q;
  logic                   expect_sog_q;
  logic                   gat_ready_q;
  logic                   need_vec;
  logic                   last_word;

  // A new vector is due at sog, or right after an eog entry
  assign need_vec  = idx_rd_data.sog || expect_sog_q;
  assign last_word = (word_cnt_q == LAST_WORD);

  // Address already points at the next entry while writing,
  // so the last write cycle doubles as the next read
  assign idx_rd_addr = entry_addr_q;

  assign fifo_pop  = (state_q == S_LOAD) && !fifo_empty;
  assign h_wr_en   = (state_q == S_WRITE);
  assign h_wr_addr = gat_pkg::h_addr_t'(entry_q.node_idx * `GAT_NUM_FEAT_OUT + word_cnt_q);
  assign h_wr_data = vec_q[word_cnt_q];
  assign gat_ready = gat_ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= S_IDLE;
      entry_addr_q <= '0;
      word_cnt_q   <= '0;
      last_q       <= 1'b0;
      expect_sog_q <= 1'b0;
      gat_ready_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start) begin
            entry_addr_q <= '0;
            // First entry always opens a subgraph
            expect_sog_q <= 1'b1;
            state_q      <= S_FETCH;
          end
        end
        S_FETCH: begin
          state_q <= S_LATCH;
        end
        S_LATCH: begin
          last_q       <= (entry_addr_q == LAST_ENTRY);
          expect_sog_q <= idx_rd_data.eog;
          word_cnt_q   <= '0;
          if (entry_addr_q != LAST_ENTRY) begin
            entry_addr_q <= entry_addr_q + 1'b1;
          end
          state_q <= need_vec ? S_LOAD : S_WRITE;
        end
        S_LOAD: begin
          // Stall here until the aggregator supplies a vector
          if (!fifo_empty) begin
            state_q <= S_WRITE;
          end
        end
        S_WRITE: begin
          word_cnt_q <= word_cnt_q + 1'b1;
          if (last_word) begin
            if (last_q) begin
              gat_ready_q <= 1'b1;
              state_q     <= S_DONE;
            end else begin
              state_q <= S_LATCH;
            end
          end
        end
        S_DONE: begin
          // Held until reset
          state_q <= S_DONE;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Current entry and vector
  always_ff @(posedge clk) begin
    if (state_q == S_LATCH) begin
      entry_q <= idx_rd_data;
    end
    if (fifo_pop) begin
      vec_q <= fifo_dout;
    end
  end

endmodule

/* hw/subgraph_index_ram.sv */
`include "gat_settings.svh"

module subgraph_index_ram (
  input  logic                   clk,
  input  logic                   wr_en,
  input  gat_pkg::entry_addr_t   wr_addr,
  input  gat_pkg::sg_entry_t     wr_data,
  input  gat_pkg::entry_addr_t   rd_addr,
  output gat_pkg::sg_entry_t     rd_data
);

  // Block memory model of the subgraph member list
  gat_pkg::sg_entry_t mem [`GAT_TOTAL_ENTRIES];

  // Loaded from outside before the walk
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* include/gat_settings.svh */
`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// Words per output feature vector
`define GAT_NUM_FEAT_OUT 4

// Bits per feature word
`define GAT_FEAT_WIDTH 16

// Rows in the H data memory
`define GAT_NUM_NODES 8

// Entries in the subgraph index list
`define GAT_TOTAL_ENTRIES 12

// Feature vectors the input FIFO can hold
`define GAT_FIFO_DEPTH 4

`endif

/* testbench/gat_writeback_props.sv */
`include "gat_settings.svh"

module gat_writeback_props (
  input logic             clk,
  input logic             rst_n,
  input logic             gat_ready,
  input logic             h_wr_en,
  input gat_pkg::h_addr_t h_wr_addr,
  input logic             fifo_pop,
  input logic             new_feat_vld,
  input logic             new_feat_rdy
);

  localparam int N_WORD     = `GAT_NUM_FEAT_OUT;
  localparam int ALL_WRITES = `GAT_TOTAL_ENTRIES * `GAT_NUM_FEAT_OUT;

  // Vectors inside the FIFO as seen from the handshake and the pops
  int occ_q;
  // H words written since reset
  int wr_cnt_q;
  int fail_cnt = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ_q    <= 0;
      wr_cnt_q <= 0;
    end else begin
      occ_q    <= occ_q + int'(new_feat_vld && new_feat_rdy) - int'(fifo_pop);
      wr_cnt_q <= wr_cnt_q + int'(h_wr_en);
    end
  end

  // Done rises with the last H write and holds until reset
  ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready == (wr_cnt_q == ALL_WRITES))
    else begin
      $error("gat_ready does not match the number of H writes");
      fail_cnt++;
    end

  // Each write burst covers one row from word 0 upward
  wr_row_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(h_wr_en) |-> ((int'(h_wr_addr) % N_WORD) == 0))
    else begin
      $error("H write burst does not start at word 0 of a row");
      fail_cnt++;
    end

  wr_row_step: assert property (@(posedge clk) disable iff (!rst_n)
    (h_wr_en && $past(h_wr_en)) |-> (int'(h_wr_addr) == int'($past(h_wr_addr)) + 1))
    else begin
      $error("H write address did not step by one word");
      fail_cnt++;
    end

  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_pop |-> (occ_q > 0))
    else begin
      $error("FIFO popped while empty");
      fail_cnt++;
    end

  rdy_low_full: assert property (@(posedge clk) disable iff (!rst_n)
    (occ_q == `GAT_FIFO_DEPTH) |-> !new_feat_rdy)
    else begin
      $error("new_feat_rdy high while FIFO full");
      fail_cnt++;
    end

endmodule

bind gat_writeback_top gat_writeback_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .gat_ready    (gat_ready),
  .h_wr_en      (h_wr_en),
  .h_wr_addr    (h_wr_addr),
  .fifo_pop     (fifo_pop),
  .new_feat_vld (new_feat_vld),
  .new_feat_rdy (new_feat_rdy)
);

/* testbench/gat_writeback_tb.sv */
`include "gat_settings.svh"

module gat_writeback_tb;

  localparam int TIMEOUT = 400;
  localparam int NUM_VEC = `GAT_FIFO_DEPTH;
  localparam int N_ENT   = `GAT_TOTAL_ENTRIES;
  localparam int N_WORD  = `GAT_NUM_FEAT_OUT;

  logic                 clk = 1'b0;
  logic                 rst_n;
  gat_pkg::feat_vec_t   new_feat;
  logic                 new_feat_vld;
  logic                 new_feat_rdy;
  logic                 idx_wr_en;
  gat_pkg::entry_addr_t idx_wr_addr;
  gat_pkg::sg_entry_t   idx_wr_data;
  logic                 start;
  gat_pkg::h_addr_t     h_rd_addr;
  gat_pkg::feat_t       h_rd_data;
  logic                 gat_ready;

  // Reference copies of the index list, the vectors and H rows
  gat_pkg::sg_entry_t   idx_list [N_ENT];
  gat_pkg::feat_vec_t   vecs [NUM_VEC];
  gat_pkg::feat_vec_t   exp_h [`GAT_NUM_NODES];
  logic [31:0]          lcg_state = 32'd812;
  int                   err_cnt = 0;
  int                   timeout_cnt = 0;

  gat_writeback_top u_dut (.*);

  always #5 clk = ~clk;

  function automatic gat_pkg::feat_t lcg_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  task automatic check_feat(input string name, input gat_pkg::feat_t exp,
                            input gat_pkg::feat_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s: expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s: expected %b, got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
  endtask

  // One subgraph over every row to zero H
  task automatic build_clear_list();
    for (int i = 0; i < N_ENT; i++) begin
      idx_list[i] = '{sog: (i == 0), node_idx: gat_pkg::node_idx_t'(i % `GAT_NUM_NODES),
                      eog: (i == N_ENT - 1)};
    end
  endtask

  // Subgraphs of 5, 4 and 3 members with node 7 never listed
  task automatic build_scatter_list();
    int nodes [N_ENT] = '{0, 1, 2, 3, 4, 2, 5, 6, 1, 5, 0, 3};
    for (int i = 0; i < N_ENT; i++) begin
      idx_list[i] = '{sog: (i == 0 || i == 5 || i == 9),
                      node_idx: gat_pkg::node_idx_t'(nodes[i]),
                      eog: (i == 4 || i == 8 || i == 11)};
    end
  endtask

  // Each sog opens the next vector and later entries overwrite earlier rows
  task automatic build_expected();
    int v;
    v = -1;
    for (int i = 0; i < N_ENT; i++) begin
      if (idx_list[i].sog) begin
        v++;
      end
      exp_h[idx_list[i].node_idx] = vecs[v];
    end
  endtask

  task automatic fill_vectors();
    for (int i = 0; i < NUM_VEC; i++) begin
      for (int k = 0; k < N_WORD; k++) begin
        vecs[i][k] = lcg_word();
      end
    end
  endtask

  task automatic load_index();
    for (int i = 0; i < N_ENT; i++) begin
      idx_wr_en   = 1'b1;
      idx_wr_addr = gat_pkg::entry_addr_t'(i);
      idx_wr_data = idx_list[i];
      @(negedge clk);
    end
    idx_wr_en = 1'b0;
  endtask

  task automatic send_vector(input gat_pkg::feat_vec_t v);
    int waited;
    waited       = 0;
    new_feat     = v;
    new_feat_vld = 1'b1;
    while (!new_feat_rdy && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!new_feat_rdy) begin
      $display("Timeout: FIFO never accepted a vector at t=%0t", $time);
      timeout_cnt++;
    end
    @(negedge clk);
    new_feat_vld = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!gat_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!gat_ready) begin
      $display("Timeout: gat_ready did not rise within %0d cycles", TIMEOUT);
      timeout_cnt++;
    end
  endtask

  task automatic read_h(input int node);
    gat_pkg::h_addr_t addr;
    for (int k = 0; k < N_WORD; k++) begin
      addr      = gat_pkg::h_addr_t'(node * N_WORD + k);
      h_rd_addr = addr;
      @(negedge clk);
      check_feat($sformatf("h_rd_data[%0d]", addr), exp_h[node][k], h_rd_data);
    end
  endtask

  task automatic check_all_rows();
    for (int n = 0; n < `GAT_NUM_NODES; n++) begin
      read_h(n);
    end
  endtask

  task automatic test_reset_state();
    check_bit("gat_ready", 1'b0, gat_ready);
    check_bit("new_feat_rdy", 1'b1, new_feat_rdy);
  endtask

  task automatic test_clear_pass();
    for (int i = 0; i < NUM_VEC; i++) begin
      vecs[i] = '0;
    end
    build_clear_list();
    build_expected();
    load_index();
    send_vector(vecs[0]);
    pulse_start();
    wait_ready();
    check_all_rows();
  endtask

  task automatic test_scatter();
    apply_reset();
    fill_vectors();
    build_scatter_list();
    build_expected();
    load_index();
    for (int i = 0; i < 3; i++) begin
      send_vector(vecs[i]);
    end
    pulse_start();
    wait_ready();
    check_all_rows();
  endtask

  // Walk starts with an empty FIFO and must wait for supply
  task automatic test_supply_stall();
    apply_reset();
    fill_vectors();
    build_expected();
    load_index();
    pulse_start();
    repeat (50) begin
      check_bit("gat_ready", 1'b0, gat_ready);
      @(negedge clk);
    end
    for (int i = 0; i < 3; i++) begin
      send_vector(vecs[i]);
    end
    wait_ready();
    check_all_rows();
  endtask

  task automatic test_back_pressure();
    int waited;
    waited = 0;
    apply_reset();
    fill_vectors();
    build_expected();
    load_index();
    for (int i = 0; i < NUM_VEC; i++) begin
      send_vector(vecs[i]);
    end
    check_bit("new_feat_rdy", 1'b0, new_feat_rdy);
    pulse_start();
    while (!new_feat_rdy && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!new_feat_rdy) begin
      $display("Timeout: new_feat_rdy stayed low after start");
      timeout_cnt++;
    end
    wait_ready();
    check_all_rows();
  endtask

  task automatic test_sticky_ready();
    repeat (20) begin
      @(negedge clk);
      check_bit("gat_ready", 1'b1, gat_ready);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    new_feat     = '0;
    new_feat_vld = 1'b0;
    idx_wr_en    = 1'b0;
    idx_wr_addr  = '0;
    idx_wr_data  = '0;
    start        = 1'b0;
    h_rd_addr    = '0;
    apply_reset();
    test_reset_state();
    test_clear_pass();
    test_scatter();
    test_supply_stall();
    test_back_pressure();
    test_sticky_ready();
    $display("Errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
             err_cnt, timeout_cnt, u_dut.u_props.fail_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
